/* bench/ex_input.txt */
// op a b c alu_waddr waddr csr_rdata lsu_rdata lsu_err wb_stall exp_fw exp_br
// all hex, one row per test, a row with op ff ends the list
00 00000005 00000007 00000000 01 00 00000000 00000000 0 0 0000000c 0
01 00000003 00000005 00000000 02 00 00000000 00000000 0 0 fffffffe 0
02 f0f0ff00 0ff00ff0 00000000 03 00 00000000 00000000 0 0 00f00f00 0
03 12340000 00005678 00000000 04 00 00000000 00000000 0 0 12345678 0
04 aaaaaaaa ffff0000 00000000 05 00 00000000 00000000 0 0 5555aaaa 0
05 00000001 00000024 00000000 06 00 00000000 00000000 0 0 00000010 0
06 80000000 0000001f 00000000 07 00 00000000 00000000 0 0 00000001 0
07 80000000 00000004 00000000 08 00 00000000 00000000 0 0 f8000000 0
08 ffffffff 00000001 00000000 09 00 00000000 00000000 0 0 00000001 0
09 ffffffff 00000001 00000000 0a 00 00000000 00000000 0 0 00000000 0
0a 00001234 00001234 00000400 00 00 00000000 00000000 0 0 00000000 1
0b 00000001 00000001 00000800 00 00 00000000 00000000 0 0 00000000 0
0c fffffff0 00000010 00000c00 00 00 00000000 00000000 0 3 00000000 1
0d 00000005 fffffffb 00001000 00 00 00000000 00000000 0 0 00000000 1
0e 00001234 00010000 00000000 0b 00 00000000 00000000 0 0 12340000 0
0f 80000000 80000000 00000000 0c 00 00000000 00000000 0 0 40000000 0
0f ffffffff 00000002 00000000 0d 00 00000000 00000000 0 0 ffffffff 0
0f 12345678 00010000 00000000 0e 00 00000000 00000000 0 4 00001234 0
10 00000000 00000000 00000000 0f 00 0badcafe 00000000 0 0 0badcafe 0
11 00000000 00000000 00000000 00 15 00000000 c0ffee00 0 0 00000000 0
11 00000000 00000000 00000000 00 16 00000000 12345678 1 0 00000000 0
00 7fffffff 00000001 00000000 10 00 00000000 00000000 0 5 80000000 0
06 f0000000 00000004 00000000 11 00 00000000 00000000 0 2 0f000000 0
ff 00000000 00000000 00000000 00 00 00000000 00000000 0 0 00000000 0

/* bench/ex_checks.svh */
`ifndef EX_CHECKS_SVH
`define EX_CHECKS_SVH

//////////////////////////////
// Random source
//////////////////////////////

// 32-bit LCG step, full period modulo 2^32
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

//////////////////////////////
// Reference model
//////////////////////////////

// Signed order by biasing the sign bit, then an unsigned compare
function automatic logic signed_less(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
  return (a ^ {1'b1, {(XLEN-1){1'b0}}}) < (b ^ {1'b1, {(XLEN-1){1'b0}}});
endfunction

// Forwarded word for the ALU opcodes, zero for anything else
function automatic logic [XLEN-1:0] ref_result(input ex_op_e op, input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
  logic [2*XLEN-1:0] wide;
  logic [4:0]        sh;
  sh   = b[4:0];
  // Arithmetic shift as a logical shift of the sign-extended word
  wide = {{XLEN{a[XLEN-1]}}, a} >> sh;
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_AND:  return a & b;
    OP_OR:   return a | b;
    OP_XOR:  return a ^ b;
    OP_SLL:  return a << sh;
    OP_SRL:  return a >> sh;
    OP_SRA:  return wide[XLEN-1:0];
    OP_SLT:  return {{(XLEN-1){1'b0}}, signed_less(a, b)};
    OP_SLTU: return {{(XLEN-1){1'b0}}, a < b};
    default: return '0;
  endcase
endfunction

// Branch relation, never taken outside the four branch opcodes
function automatic logic ref_branch(input ex_op_e op, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b);
  case (op)
    OP_BEQ:  return a == b;
    OP_BNE:  return a != b;
    OP_BLT:  return signed_less(a, b);
    OP_BGE:  return !signed_less(a, b);
    default: return 1'b0;
  endcase
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_word(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
  if (got !== exp) begin
    $display("MISMATCH t=%0t %s: got %h, expected %h", $time, name, got, exp);
    err_cnt++;
    test_bad = 1'b1;
  end
endtask

task automatic check_addr(input string name, input logic [REG_ADDR_W-1:0] got,
                          input logic [REG_ADDR_W-1:0] exp);
  if (got !== exp) begin
    $display("MISMATCH t=%0t %s: got %h, expected %h", $time, name, got, exp);
    err_cnt++;
    test_bad = 1'b1;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("MISMATCH t=%0t %s: got %b, expected %b", $time, name, got, exp);
    err_cnt++;
    test_bad = 1'b1;
  end
endtask

// Cycle counts from first presentation to acceptance
task automatic check_cycles(input string name, input int got, input int exp);
  if (got != exp) begin
    $display("MISMATCH t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
    err_cnt++;
    test_bad = 1'b1;
  end
endtask

`endif

/* bench/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb;
  import ex_pkg::*;

  localparam int ROW_WORDS  = 12;
  localparam int MAX_ROWS   = 64;
  localparam int RAND_TESTS = 64;
  localparam int MARGIN     = 50;

  // DUT inputs
  logic                  clk;
  logic                  rst_n;
  logic                  op_valid_i;
  ex_op_e                ex_op_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       operand_b_i;
  logic [XLEN-1:0]       operand_c_i;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i;
  logic [REG_ADDR_W-1:0] regfile_waddr_i;
  logic [XLEN-1:0]       csr_rdata_i;
  logic [XLEN-1:0]       lsu_rdata_i;
  logic                  lsu_ready_ex_i;
  logic                  lsu_err_i;
  logic                  wb_ready_i;

  // DUT outputs
  logic                  regfile_alu_we_fw_o;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic [XLEN-1:0]       regfile_alu_wdata_fw_o;
  logic                  regfile_we_wb_o;
  logic [REG_ADDR_W-1:0] regfile_waddr_wb_o;
  logic [XLEN-1:0]       regfile_wdata_wb_o;
  logic                  ex_ready_o;
  logic                  ex_valid_o;
  logic                  branch_decision_o;
  logic [XLEN-1:0]       jump_target_o;
  logic                  mult_multicycle_o;

  // Vector rows, flat, ROW_WORDS words per row
  logic [31:0] vec_mem [0:ROW_WORDS*MAX_ROWS-1];

  // Test in flight
  ex_op_e                cur_op;
  logic [XLEN-1:0]       cur_a;
  logic [XLEN-1:0]       cur_b;
  logic [XLEN-1:0]       cur_c;
  logic [XLEN-1:0]       cur_csr;
  logic [XLEN-1:0]       cur_lsu;
  logic [XLEN-1:0]       cur_exp;
  logic [REG_ADDR_W-1:0] cur_alu_waddr;
  logic [REG_ADDR_W-1:0] cur_waddr;
  logic                  cur_err;
  logic                  cur_exp_br;
  int                    cur_stall;

  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  int          row_cnt;
  int          max_stall;
  logic        test_bad;
  logic [31:0] rng_state;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;

  `include "ex_checks.svh"

  ex_stage dut (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .op_valid_i            (op_valid_i),
    .ex_op_i               (ex_op_i),
    .operand_a_i           (operand_a_i),
    .operand_b_i           (operand_b_i),
    .operand_c_i           (operand_c_i),
    .regfile_alu_waddr_i   (regfile_alu_waddr_i),
    .regfile_waddr_i       (regfile_waddr_i),
    .csr_rdata_i           (csr_rdata_i),
    .lsu_rdata_i           (lsu_rdata_i),
    .lsu_ready_ex_i        (lsu_ready_ex_i),
    .lsu_err_i             (lsu_err_i),
    .wb_ready_i            (wb_ready_i),
    .regfile_alu_we_fw_o   (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw_o),
    .regfile_we_wb_o       (regfile_we_wb_o),
    .regfile_waddr_wb_o    (regfile_waddr_wb_o),
    .regfile_wdata_wb_o    (regfile_wdata_wb_o),
    .ex_ready_o            (ex_ready_o),
    .ex_valid_o            (ex_valid_o),
    .branch_decision_o     (branch_decision_o),
    .jump_target_o         (jump_target_o),
    .mult_multicycle_o     (mult_multicycle_o)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit in clock cycles, armed once the vector file is read
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic is_branch_op(input ex_op_e op);
    return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE};
  endfunction

  task automatic report_test(input string label);
    test_cnt++;
    if (test_bad) fail_cnt++;
    $display("test %0d %s: %s", test_cnt, label, test_bad ? "FAILED" : "ok");
  endtask

  //////////////////////////////
  // Acceptance checks
  //////////////////////////////

  // Sampled in the cycle whose closing edge accepts the instruction
  task automatic check_accept(input int cyc);
    int exp_cyc;
    if (is_branch_op(cur_op)) begin
      exp_cyc = 1;
    end else if (cur_op == OP_MULH && cur_stall + 1 < MULH_CYCLES) begin
      exp_cyc = MULH_CYCLES;
    end else begin
      exp_cyc = cur_stall + 1;
    end
    check_cycles("accept cycle", cyc, exp_cyc);
    check_bit("branch_decision_o", branch_decision_o, cur_exp_br);
    if (is_branch_op(cur_op)) begin
      check_word("jump_target_o", jump_target_o, cur_c);
      check_bit("ex_valid_o", ex_valid_o, 1'b0);
      check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, 1'b0);
    end else begin
      check_bit("ex_valid_o", ex_valid_o, 1'b1);
      if (cur_op == OP_LOAD) begin
        check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, 1'b0);
      end else begin
        check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, 1'b1);
        check_addr("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw_o, cur_alu_waddr);
        check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, cur_exp);
      end
    end
  endtask

  // Present cur_* until accepted, wb_ready_i low for the first cur_stall cycles
  task automatic exec_test();
    int cyc;
    bit done;
    cyc      = 0;
    done     = 1'b0;
    test_bad = 1'b0;
    @(posedge clk);
    op_valid_i          <= 1'b1;
    ex_op_i             <= cur_op;
    operand_a_i         <= cur_a;
    operand_b_i         <= cur_b;
    operand_c_i         <= cur_c;
    regfile_alu_waddr_i <= cur_alu_waddr;
    regfile_waddr_i     <= cur_waddr;
    csr_rdata_i         <= cur_csr;
    lsu_rdata_i         <= cur_lsu;
    lsu_err_i           <= cur_err;
    wb_ready_i          <= (cur_stall == 0);
    while (!done) begin
      @(negedge clk);
      cyc++;
      // Back-pressure holds non-branch instructions
      if (!is_branch_op(cur_op) && cyc <= cur_stall) begin
        check_bit("ex_ready_o", ex_ready_o, 1'b0);
        check_bit("ex_valid_o", ex_valid_o, 1'b0);
      end
      if (cur_op == OP_MULH && cyc < MULH_CYCLES) begin
        check_bit("mult_multicycle_o", mult_multicycle_o, 1'b1);
        check_bit("ex_ready_o", ex_ready_o, 1'b0);
      end
      if (ex_ready_o) begin
        done = 1'b1;
        check_accept(cyc);
      end
      @(posedge clk);
      if (done || cyc >= cur_stall) wb_ready_i <= 1'b1;
      if (done) begin
        op_valid_i <= 1'b0;
        ex_op_i    <= OP_NOP;
      end
    end
    // Load reaches the write-back port one cycle later
    if (cur_op == OP_LOAD) begin
      @(negedge clk);
      check_bit("regfile_we_wb_o", regfile_we_wb_o, ~cur_err);
      if (!cur_err) begin
        check_addr("regfile_waddr_wb_o", regfile_waddr_wb_o, cur_waddr);
        check_word("regfile_wdata_wb_o", regfile_wdata_wb_o, cur_lsu);
      end
    end
    report_test(cur_op.name());
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int base;
    rst_n               = 1'b0;
    op_valid_i          = 1'b0;
    ex_op_i             = OP_NOP;
    operand_a_i         = '0;
    operand_b_i         = '0;
    operand_c_i         = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
    csr_rdata_i         = '0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    wb_ready_i          = 1'b1;
    err_cnt             = 0;
    test_cnt            = 0;
    fail_cnt            = 0;
    rng_state           = 32'hca0c;

    // Unread words keep an address-dependent marker
    for (int i = 0; i < ROW_WORDS * MAX_ROWS; i++) begin
      vec_mem[i] = 32'hdead_0000 ^ 32'(i);
    end
    $readmemh("bench/ex_input.txt", vec_mem);
    row_cnt   = 0;
    max_stall = 0;
    while (row_cnt < MAX_ROWS && vec_mem[row_cnt * ROW_WORDS] != 32'hff) begin
      if (int'(vec_mem[row_cnt * ROW_WORDS + 9]) > max_stall) begin
        max_stall = int'(vec_mem[row_cnt * ROW_WORDS + 9]);
      end
      row_cnt++;
    end
    if (row_cnt == MAX_ROWS || row_cnt == 0) begin
      $display("Vector file is empty or lacks its end row");
      err_cnt++;
    end
    cycle_limit = (row_cnt + RAND_TESTS) * (MULH_CYCLES + max_stall + 2) + 16 + MARGIN;

    // Reset for 16 cycles
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_bad = 1'b0;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    check_bit("mult_multicycle_o", mult_multicycle_o, 1'b0);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, 1'b0);
    report_test("reset");

    // Directed rows
    for (int r = 0; r < row_cnt; r++) begin
      base          = r * ROW_WORDS;
      cur_op        = ex_op_e'(vec_mem[base][4:0]);
      cur_a         = vec_mem[base + 1];
      cur_b         = vec_mem[base + 2];
      cur_c         = vec_mem[base + 3];
      cur_alu_waddr = vec_mem[base + 4][REG_ADDR_W-1:0];
      cur_waddr     = vec_mem[base + 5][REG_ADDR_W-1:0];
      cur_csr       = vec_mem[base + 6];
      cur_lsu       = vec_mem[base + 7];
      cur_err       = vec_mem[base + 8][0];
      cur_stall     = int'(vec_mem[base + 9]);
      cur_exp       = vec_mem[base + 10];
      cur_exp_br    = vec_mem[base + 11][0];
      exec_test();
    end

    // Random ALU and branch instructions, no back-pressure
    for (int n = 0; n < RAND_TESTS; n++) begin
      rng_state = lcg_next(rng_state);
      cur_op    = ex_op_e'(5'((rng_state >> 16) % 32'd14));
      rng_state = lcg_next(rng_state);
      cur_a     = rng_state;
      rng_state = lcg_next(rng_state);
      cur_b     = rng_state;
      // Equal operands now and then so BEQ can be taken
      if ((cur_op == OP_BEQ || cur_op == OP_BNE) && rng_state[20]) cur_b = cur_a;
      rng_state     = lcg_next(rng_state);
      cur_c         = rng_state;
      cur_alu_waddr = rng_state[16 +: REG_ADDR_W];
      cur_waddr     = rng_state[24 +: REG_ADDR_W];
      cur_csr       = '0;
      cur_lsu       = '0;
      cur_err       = 1'b0;
      cur_stall     = 0;
      cur_exp       = ref_result(cur_op, cur_a, cur_b);
      cur_exp_br    = ref_branch(cur_op, cur_a, cur_b);
      exec_test();
    end

    @(posedge clk);
    $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+bench
logic/ex_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_writeback.sv
logic/ex_stage.sv
bench/ex_stage_tb.sv

/* logic/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_op_e             alu_op_i,
  input  logic [ex_pkg::XLEN-1:0]     operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]     operand_b_i,
  output logic [ex_pkg::XLEN-1:0]     result_o,
  output logic                        cmp_result_o
);
  import ex_pkg::*;

  logic                    adder_sub;
  logic [XLEN-1:0]         adder_b;
  logic [XLEN-1:0]         adder_result;
  logic [$clog2(XLEN)-1:0] shamt;
  logic                    is_equal;
  logic                    lt_signed;
  logic                    lt_unsigned;

  //////////////////////////////
  // Shared adder
  //////////////////////////////

  // Subtract as a + ~b + 1
  assign adder_sub    = (alu_op_i == ALU_SUB);
  assign adder_b      = adder_sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + {{(XLEN-1){1'b0}}, adder_sub};

  // Shift amount from the low bits of b only
  assign shamt = operand_b_i[$clog2(XLEN)-1:0];

  //////////////////////////////
  // Comparators
  //////////////////////////////

  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // Result select
  always_comb begin
    result_o = '0;
    case (alu_op_i)
      ALU_ADD, ALU_SUB: result_o = adder_result;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign of a
      ALU_SRA:  result_o = $signed(operand_a_i) >>> shamt;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:  result_o = '0;
    endcase
  end

  // Branch relation, low for any non-compare operator
  always_comb begin
    case (alu_op_i)
      ALU_EQ:  cmp_result_o = is_equal;
      ALU_NE:  cmp_result_o = ~is_equal;
      ALU_LT:  cmp_result_o = lt_signed;
      ALU_GE:  cmp_result_o = ~lt_signed;
      default: cmp_result_o = 1'b0;
    endcase
  end

endmodule

/* logic/ex_decode.sv */
`timescale 1ns/1ps

module ex_decode (
  input  logic            op_valid_i,
  input  ex_pkg::ex_op_e  ex_op_i,
  output logic            alu_en_o,
  output logic            mult_en_o,
  output logic            csr_en_o,
  output logic            lsu_en_o,
  output logic            branch_en_o,
  output logic            alu_we_o,
  output ex_pkg::alu_op_e alu_op_o,
  output ex_pkg::mul_op_e mul_op_o
);
  import ex_pkg::*;

  always_comb begin
    // Idle defaults, also used for NOP and unknown opcodes
    alu_en_o    = 1'b0;
    mult_en_o   = 1'b0;
    csr_en_o    = 1'b0;
    lsu_en_o    = 1'b0;
    branch_en_o = 1'b0;
    alu_we_o    = 1'b0;
    alu_op_o    = ALU_ADD;
    mul_op_o    = MUL_L;
    if (op_valid_i) begin
      // Unit select, exactly one unit per opcode
      case (ex_op_i)
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU: begin
          alu_en_o = 1'b1;
          alu_we_o = 1'b1;
        end
        // Branches only use the ALU comparator, no register write
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE: branch_en_o = 1'b1;
        OP_MUL, OP_MULH: begin
          mult_en_o = 1'b1;
          alu_we_o  = 1'b1;
        end
        OP_CSR: begin
          csr_en_o = 1'b1;
          alu_we_o = 1'b1;
        end
        OP_LOAD: lsu_en_o = 1'b1;
        default: ;
      endcase
      // Operator select
      case (ex_op_i)
        OP_SUB:  alu_op_o = ALU_SUB;
        OP_AND:  alu_op_o = ALU_AND;
        OP_OR:   alu_op_o = ALU_OR;
        OP_XOR:  alu_op_o = ALU_XOR;
        OP_SLL:  alu_op_o = ALU_SLL;
        OP_SRL:  alu_op_o = ALU_SRL;
        OP_SRA:  alu_op_o = ALU_SRA;
        OP_SLT:  alu_op_o = ALU_SLT;
        OP_SLTU: alu_op_o = ALU_SLTU;
        OP_BEQ:  alu_op_o = ALU_EQ;
        OP_BNE:  alu_op_o = ALU_NE;
        OP_BLT:  alu_op_o = ALU_LT;
        OP_BGE:  alu_op_o = ALU_GE;
        OP_MULH: mul_op_o = MUL_H;
        default: ;
      endcase
    end
  end

endmodule

/* logic/ex_mult.sv */
`timescale 1ns/1ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable_i,
  input  ex_pkg::mul_op_e         mul_op_i,
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o,
  output logic                    multicycle_o
);
  import ex_pkg::*;

  localparam int HALF = XLEN / 2;

  mulh_state_e                   state_q;
  mulh_state_e                   state_d;
  logic                          mulh_req;
  logic [XLEN-1:0]               mul_lo;
  logic signed [XLEN+HALF:0]     pp_lo;
  logic signed [XLEN+HALF-1:0]   pp_hi;
  logic [2*XLEN-1:0]             acc_q;

  assign mulh_req = enable_i && (mul_op_i == MUL_H);

  // Low word in a single cycle
  assign mul_lo = op_a_i * op_b_i;

  //////////////////////////////
  // High multiply partials
  //////////////////////////////

  // Operands are widened to the partial product width
  // Low half of b is unsigned, so it is zero extended before the signed multiply
  assign pp_lo = $signed({{(HALF+1){op_a_i[XLEN-1]}}, op_a_i})
               * $signed({{(XLEN+1){1'b0}}, op_b_i[HALF-1:0]});
  // Upper half of b carries the sign
  assign pp_hi = $signed({{HALF{op_a_i[XLEN-1]}}, op_a_i})
               * $signed({{XLEN{op_b_i[XLEN-1]}}, op_b_i[XLEN-1:HALF]});

  // Sequencer next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      MH_IDLE: if (mulh_req) state_d = MH_PART;
      MH_PART: state_d = MH_DONE;
      // Wait here until the stage takes the result
      MH_DONE: if (ex_ready_i) state_d = MH_IDLE;
      default: state_d = MH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Accumulator loads the first partial and then adds the shifted second
  always_ff @(posedge clk) begin
    if ((state_q == MH_IDLE) && mulh_req) begin
      acc_q <= {{(HALF-1){pp_lo[XLEN+HALF]}}, pp_lo};
    end else if (state_q == MH_PART) begin
      acc_q <= acc_q + {pp_hi, {HALF{1'b0}}};
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Upper word only meaningful in MH_DONE
  assign result_o     = (mul_op_i == MUL_H) ? acc_q[2*XLEN-1:XLEN] : mul_lo;
  assign ready_o      = ~mulh_req | (state_q == MH_DONE);
  assign multicycle_o = mulh_req & (state_q != MH_DONE);

endmodule

/* logic/ex_pkg.sv */
package ex_pkg;

  //////////////////////////////
  // Widths and timing
  //////////////////////////////

  // Data word width
  localparam int XLEN        = 32;
  // Register file write address width
  localparam int REG_ADDR_W  = 6;
  // Cycles a high multiply holds the stage
  localparam int MULH_CYCLES = 3;

  //////////////////////////////
  // Opcodes and states
  //////////////////////////////

  // Execute opcode presented to the stage
  typedef enum logic [4:0] {
    OP_ADD  = 5'h00,
    OP_SUB  = 5'h01,
    OP_AND  = 5'h02,
    OP_OR   = 5'h03,
    OP_XOR  = 5'h04,
    OP_SLL  = 5'h05,
    OP_SRL  = 5'h06,
    OP_SRA  = 5'h07,
    OP_SLT  = 5'h08,
    OP_SLTU = 5'h09,
    OP_BEQ  = 5'h0a,
    OP_BNE  = 5'h0b,
    OP_BLT  = 5'h0c,
    OP_BGE  = 5'h0d,
    OP_MUL  = 5'h0e,
    OP_MULH = 5'h0f,
    OP_CSR  = 5'h10,
    OP_LOAD = 5'h11,
    OP_NOP  = 5'h1f
  } ex_op_e;

  // ALU operator, arithmetic/logic subset plus the four compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE
  } alu_op_e;

  // Multiplier operator
  typedef enum logic {MUL_L, MUL_H} mul_op_e;

  // High multiply sequencer
  typedef enum logic [1:0] {MH_IDLE, MH_PART, MH_DONE} mulh_state_e;

endpackage

/* logic/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          op_valid_i,
  input  ex_pkg::ex_op_e                ex_op_i,
  input  logic [ex_pkg::XLEN-1:0]       operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]       operand_b_i,
  input  logic [ex_pkg::XLEN-1:0]       operand_c_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,
  input  logic                          wb_ready_i,
  output logic                          regfile_alu_we_fw_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_alu_wdata_fw_o,
  output logic                          regfile_we_wb_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_wdata_wb_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  output logic                          branch_decision_o,
  output logic [ex_pkg::XLEN-1:0]       jump_target_o,
  output logic                          mult_multicycle_o
);
  import ex_pkg::*;

  logic            alu_en;
  logic            mult_en;
  logic            csr_en;
  logic            lsu_en;
  logic            branch_en;
  logic            alu_we;
  alu_op_e         alu_op;
  mul_op_e         mul_op;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  // Decode
  ex_decode u_decode (
    .op_valid_i (op_valid_i),
    .ex_op_i    (ex_op_i),
    .alu_en_o   (alu_en),
    .mult_en_o  (mult_en),
    .csr_en_o   (csr_en),
    .lsu_en_o   (lsu_en),
    .branch_en_o(branch_en),
    .alu_we_o   (alu_we),
    .alu_op_o   (alu_op),
    .mul_op_o   (mul_op)
  );

  // ALU and branch compare
  ex_alu u_alu (
    .alu_op_i    (alu_op),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (alu_result),
    .cmp_result_o(alu_cmp)
  );

  // Target comes precomputed from ID
  assign branch_decision_o = branch_en & alu_cmp;
  assign jump_target_o     = operand_c_i;

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  ex_mult u_mult (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (mult_en),
    .mul_op_i    (mul_op),
    .op_a_i      (operand_a_i),
    .op_b_i      (operand_b_i),
    .ex_ready_i  (ex_ready_o),
    .result_o    (mult_result),
    .ready_o     (mult_ready),
    .multicycle_o(mult_multicycle_o)
  );

  // Write ports and stage handshake
  ex_writeback u_writeback (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .alu_en_i              (alu_en),
    .mult_en_i             (mult_en),
    .csr_en_i              (csr_en),
    .lsu_en_i              (lsu_en),
    .branch_en_i           (branch_en),
    .alu_we_i              (alu_we),
    .alu_result_i          (alu_result),
    .mult_result_i         (mult_result),
    .csr_rdata_i           (csr_rdata_i),
    .lsu_rdata_i           (lsu_rdata_i),
    .mult_ready_i          (mult_ready),
    .lsu_ready_ex_i        (lsu_ready_ex_i),
    .lsu_err_i             (lsu_err_i),
    .wb_ready_i            (wb_ready_i),
    .regfile_alu_waddr_i   (regfile_alu_waddr_i),
    .regfile_waddr_i       (regfile_waddr_i),
    .regfile_alu_we_fw_o   (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw_o),
    .regfile_we_wb_o       (regfile_we_wb_o),
    .regfile_waddr_wb_o    (regfile_waddr_wb_o),
    .regfile_wdata_wb_o    (regfile_wdata_wb_o),
    .ex_ready_o            (ex_ready_o),
    .ex_valid_o            (ex_valid_o)
  );

endmodule

/* logic/ex_writeback.sv */
`timescale 1ns/1ps

module ex_writeback (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  input  logic                          csr_en_i,
  input  logic                          lsu_en_i,
  input  logic                          branch_en_i,
  input  logic                          alu_we_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_result_i,
  input  logic [ex_pkg::XLEN-1:0]       mult_result_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          mult_ready_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,
  input  logic                          wb_ready_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  output logic                          regfile_alu_we_fw_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_alu_wdata_fw_o,
  output logic                          regfile_we_wb_o,
  output logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_wdata_wb_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);
  import ex_pkg::*;

  logic                  units_ready;
  logic                  lsu_we;
  logic                  we_lsu_q;
  logic [REG_ADDR_W-1:0] waddr_lsu_q;

  //////////////////////////////
  // Forwarding port
  //////////////////////////////

  assign regfile_alu_we_fw_o    = alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Decode enables are one-hot, priority only matters for idle
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i)  regfile_alu_wdata_fw_o = alu_result_i;
    if (mult_en_i) regfile_alu_wdata_fw_o = mult_result_i;
    if (csr_en_i)  regfile_alu_wdata_fw_o = csr_rdata_i;
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // Faulting loads never reach the register file
  assign lsu_we = lsu_en_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_lsu_q <= lsu_we;
    end else if (wb_ready_i) begin
      // Nothing completing, flush the slot
      we_lsu_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && lsu_we) begin
      waddr_lsu_q <= regfile_waddr_i;
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Stage handshake, branches finish without writeback
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_en_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_en_i | lsu_en_i) & units_ready;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ex_stage_sim
LOG_FILE=sim.log

verilator --binary --timing -f files.f --top-module ex_stage_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG_FILE"; then
  echo "Simulation reported a failure, see $LOG_FILE"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
